/* Bender.yml */
package:
  name: i2c_loopback

dependencies: {}

sources:
  # Package first, then leaf modules up to the top level
  - files:
      - verilog/i2c_pkg.sv
      - verilog/i2c_word_mem.sv
      - verilog/i2c_phase_gen.sv
      - verilog/i2c_master.sv
      - verilog/i2c_slave.sv
      - verilog/i2c_loopback_top.sv

  - target: test
    files:
      - bench/i2c_tb.sv

/* bench/i2c_tb.sv */
`timescale 1ns/100ps

module i2c_tb;

    localparam int CLK_FREQ     = 1000000;
    localparam int I2C_FREQ     = 50000;
    localparam int MEM_DEPTH    = 96;
    localparam int BIT_CYCLES   = 4 * i2c_pkg::quarter_cycles(CLK_FREQ, I2C_FREQ);
    localparam int DONE_TIMEOUT = 25 * BIT_CYCLES;
    localparam int RANDOM_STEPS = 50;

    typedef struct packed {
        i2c_pkg::i2c_req_t req;
        i2c_pkg::data_t    exp_rdata;
        logic              exp_err;
    } step_t;

    logic              clk;
    logic              rst;
    logic              start;
    i2c_pkg::i2c_req_t req;
    i2c_pkg::data_t    rdata;
    logic              busy;
    logic              done;
    logic              ack_err;

    i2c_pkg::data_t model [128]; // Expected slave memory
    step_t          steps [$];

    i2c_loopback_top #(
        .CLK_FREQ (CLK_FREQ),
        .I2C_FREQ (I2C_FREQ),
        .MEM_DEPTH(MEM_DEPTH)
    ) dut0 (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .req    (req),
        .rdata  (rdata),
        .busy   (busy),
        .done   (done),
        .ack_err(ack_err)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input i2c_pkg::data_t got,
                              input i2c_pkg::data_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic i2c_pkg::i2c_req_t make_req(input logic read, input int addr,
                                                   input int data);
        i2c_pkg::i2c_req_t r;
        r.read = read;
        r.addr = i2c_pkg::dev_addr_t'(addr);
        r.data = i2c_pkg::data_t'(data);
        return r;
    endfunction

    // Expected result from the model and the NACK rule
    function automatic step_t predict(input i2c_pkg::i2c_req_t r);
        step_t s;
        s.req     = r;
        s.exp_err = (int'(r.addr) >= MEM_DEPTH);
        if (s.exp_err || !r.read)
            s.exp_rdata = '0;
        else
            s.exp_rdata = model[r.addr];
        return s;
    endfunction

    task automatic add_step(input logic read, input int addr, input int data,
                            input int exp_rdata, input logic exp_err);
        step_t s;
        s.req       = make_req(read, addr, data);
        s.exp_rdata = i2c_pkg::data_t'(exp_rdata);
        s.exp_err   = exp_err;
        steps.push_back(s);
    endtask

    task automatic update_model(input i2c_pkg::i2c_req_t r);
        if (!r.read && int'(r.addr) < MEM_DEPTH)
            model[r.addr] = r.data;
    endtask

    // One-cycle start strobe while the master is idle
    task automatic issue_start(input i2c_pkg::i2c_req_t r);
        @(posedge clk);
        #1;
        start = 1'b1;
        req   = r;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_flag("busy", busy, 1'b1);
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done) begin
            cycles++;
            if (cycles > DONE_TIMEOUT) begin
                $display("Timeout: no done pulse within %0d clock cycles", DONE_TIMEOUT);
                stop_with_failure();
            end
            @(negedge clk);
        end
        check_flag("busy", busy, 1'b0); // busy falls with done
    endtask

    task automatic apply_and_check(input step_t s);
        issue_start(s.req);
        wait_done();
        check_data("rdata", rdata, s.exp_rdata);
        check_flag("ack_err", ack_err, s.exp_err);
        update_model(s.req);
    endtask

    // Second start lands while busy and must be ignored
    task automatic check_ignored_start(input i2c_pkg::i2c_req_t first,
                                       input i2c_pkg::i2c_req_t second);
        step_t exp;
        int    quiet;
        exp = predict(first);
        issue_start(first);
        start = 1'b1;
        req   = second;
        @(posedge clk);
        #1;
        start = 1'b0;
        wait_done();
        check_data("rdata", rdata, exp.exp_rdata);
        check_flag("ack_err", ack_err, exp.exp_err);
        update_model(first);
        for (quiet = 0; quiet < 2 * BIT_CYCLES; quiet++) begin
            @(negedge clk);
            check_flag("done", done, 1'b0);
            check_flag("busy", busy, 1'b0);
        end
    endtask

    task automatic build_table();
        add_step(1'b1,   5, 8'h00, 8'h05, 1'b0);
        add_step(1'b1,  95, 8'h00, 8'h5f, 1'b0); // Last word
        add_step(1'b1,   0, 8'h00, 8'h00, 1'b0);
        add_step(1'b0,  10, 8'ha5, 8'h00, 1'b0);
        add_step(1'b1,  10, 8'h00, 8'ha5, 1'b0);
        add_step(1'b1,  11, 8'h00, 8'h0b, 1'b0); // Neighbours untouched
        add_step(1'b1,   9, 8'h00, 8'h09, 1'b0);
        add_step(1'b0,  95, 8'h3c, 8'h00, 1'b0);
        add_step(1'b1,  95, 8'h00, 8'h3c, 1'b0);
        add_step(1'b1,  96, 8'h00, 8'h00, 1'b1); // First NACK address
        add_step(1'b1, 127, 8'h00, 8'h00, 1'b1);
        add_step(1'b0, 100, 8'h77, 8'h00, 1'b1);
        add_step(1'b1,   4, 8'h00, 8'h04, 1'b0); // 100 must not alias here
        add_step(1'b0,   0, 8'hff, 8'h00, 1'b0);
        add_step(1'b1,   0, 8'h00, 8'hff, 1'b0);
        add_step(1'b1,   1, 8'h00, 8'h01, 1'b0);
        add_step(1'b0,  50, 8'h80, 8'h00, 1'b0);
        add_step(1'b1,  50, 8'h00, 8'h80, 1'b0);
    endtask

    initial begin
        i2c_pkg::i2c_req_t r;
        int                i;
        clk   = 1'b0;
        rst   = 1'b1;
        start = 1'b0;
        req   = '0;
        void'($urandom(32'hd7de8b0b));
        for (i = 0; i < 128; i++)
            model[i] = i2c_pkg::data_t'(i);
        build_table();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("ack_err", ack_err, 1'b0);

        for (i = 0; i < steps.size(); i++)
            apply_and_check(steps[i]);

        check_ignored_start(make_req(1'b1, 20, 0), make_req(1'b0, 20, 8'hee));
        apply_and_check(predict(make_req(1'b1, 20, 0))); // Ignored write left no trace
        check_ignored_start(make_req(1'b0, 30, 8'h5a), make_req(1'b1, 99, 0));
        apply_and_check(predict(make_req(1'b1, 30, 0)));

        for (i = 0; i < RANDOM_STEPS; i++) begin
            r = make_req(1'(($urandom % 2)), int'($urandom % 128), int'($urandom % 256));
            apply_and_check(predict(r));
        end

        $display("All tests passed");
        $finish;
    end

endmodule

/* tb.f */
verilog/i2c_pkg.sv
verilog/i2c_word_mem.sv
verilog/i2c_phase_gen.sv
verilog/i2c_master.sv
verilog/i2c_slave.sv
verilog/i2c_loopback_top.sv
bench/i2c_tb.sv

/* verilog/i2c_loopback_top.sv */
`timescale 1ns/100ps

module i2c_loopback_top #(
    parameter int CLK_FREQ  = 40000000,
    parameter int I2C_FREQ  = 100000,
    parameter int MEM_DEPTH = 128
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  i2c_pkg::i2c_req_t req,
    output i2c_pkg::data_t    rdata,
    output logic              busy,
    output logic              done,
    output logic              ack_err
);

    i2c_pkg::bus_drive_t m_drv;
    i2c_pkg::bus_drive_t s_drv;
    logic                scl_line;
    logic                sda_line;

    // Wired-AND, a line is high unless someone pulls it low
    assign scl_line = ~(m_drv.scl_low | s_drv.scl_low);
    assign sda_line = ~(m_drv.sda_low | s_drv.sda_low);

    i2c_master #(
        .CLK_FREQ(CLK_FREQ),
        .I2C_FREQ(I2C_FREQ)
    ) master0 (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .req     (req),
        .scl_line(scl_line),
        .sda_line(sda_line),
        .drv     (m_drv),
        .rdata   (rdata),
        .busy    (busy),
        .done    (done),
        .ack_err (ack_err)
    );

    i2c_slave #(
        .MEM_DEPTH(MEM_DEPTH)
    ) slave0 (
        .clk     (clk),
        .rst     (rst),
        .scl_line(scl_line),
        .sda_line(sda_line),
        .drv     (s_drv)
    );

endmodule

/* verilog/i2c_master.sv */
`timescale 1ns/100ps

module i2c_master #(
    parameter int CLK_FREQ = 40000000,
    parameter int I2C_FREQ = 100000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  i2c_pkg::i2c_req_t   req,
    input  logic                scl_line,
    input  logic                sda_line,
    output i2c_pkg::bus_drive_t drv,
    output i2c_pkg::data_t      rdata,
    output logic                busy,
    output logic                done,
    output logic                ack_err
);

    i2c_pkg::master_state_t state;
    i2c_pkg::phase_t        phase;
    i2c_pkg::phase_t        phase_q;
    i2c_pkg::i2c_req_t      req_q;
    i2c_pkg::data_t         shift;
    logic [2:0]             bit_cnt;
    logic                   run;
    logic                   last_cycle;
    logic                   smp_edge;
    logic                   sda_smp;
    logic                   sda_hold;
    logic                   sda_target;

    assign run = (state != i2c_pkg::M_IDLE);

    i2c_phase_gen #(
        .CLK_FREQ(CLK_FREQ),
        .I2C_FREQ(I2C_FREQ)
    ) phase_gen0 (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .phase     (phase),
        .last_cycle(last_cycle)
    );

    // First clock of PH2, SCL just went high
    assign smp_edge = (phase == i2c_pkg::PH2) && (phase_q != i2c_pkg::PH2);

    always_comb begin
        drv.scl_low = ~phase[1];
        sda_target  = 1'b0;
        case (state)
            i2c_pkg::M_IDLE:  drv.scl_low = 1'b0;
            i2c_pkg::M_START: begin
                drv.scl_low = 1'b0;
                sda_target  = phase[1]; // SDA falls with SCL high
            end
            i2c_pkg::M_ADDR,
            i2c_pkg::M_WRITE: sda_target = ~shift[7];
            i2c_pkg::M_STOP:  sda_target = (phase != i2c_pkg::PH3);
            default:          sda_target = 1'b0;
        endcase
        // SDA only moves from PH1 on
        if (state != i2c_pkg::M_IDLE && phase == i2c_pkg::PH0)
            drv.sda_low = sda_hold;
        else
            drv.sda_low = sda_target;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= i2c_pkg::M_IDLE;
            phase_q  <= i2c_pkg::PH0;
            bit_cnt  <= '0;
            sda_hold <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            ack_err  <= 1'b0;
            rdata    <= '0;
        end else begin
            phase_q  <= phase;
            sda_hold <= drv.sda_low;
            done     <= 1'b0;
            if (smp_edge) begin
                sda_smp <= sda_line;
                if (state == i2c_pkg::M_READ)
                    shift <= {shift[6:0], sda_line};
            end
            case (state)
                i2c_pkg::M_IDLE: begin
                    if (start) begin
                        req_q   <= req;
                        busy    <= 1'b1;
                        ack_err <= 1'b0;
                        rdata   <= '0;
                        state   <= i2c_pkg::M_START;
                    end
                end
                i2c_pkg::M_START: begin
                    if (last_cycle) begin
                        shift <= {req_q.addr, req_q.read};
                        state <= i2c_pkg::M_ADDR;
                    end
                end
                i2c_pkg::M_ADDR,
                i2c_pkg::M_WRITE: begin
                    if (last_cycle) begin
                        shift   <= {shift[6:0], 1'b0};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= (state == i2c_pkg::M_ADDR) ? i2c_pkg::M_ADDR_ACK
                                                                : i2c_pkg::M_SLAVE_ACK;
                    end
                end
                i2c_pkg::M_ADDR_ACK: begin
                    if (last_cycle) begin
                        if (sda_smp) begin // Address not acknowledged
                            ack_err <= 1'b1;
                            state   <= i2c_pkg::M_STOP;
                        end else if (req_q.read) begin
                            state <= i2c_pkg::M_READ;
                        end else begin
                            shift <= req_q.data;
                            state <= i2c_pkg::M_WRITE;
                        end
                    end
                end
                i2c_pkg::M_READ: begin
                    if (last_cycle) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            rdata <= shift;
                            state <= i2c_pkg::M_MASTER_ACK;
                        end
                    end
                end
                i2c_pkg::M_SLAVE_ACK: begin
                    if (last_cycle) begin
                        if (sda_smp)
                            ack_err <= 1'b1;
                        state <= i2c_pkg::M_STOP;
                    end
                end
                i2c_pkg::M_MASTER_ACK: begin
                    if (last_cycle)
                        state <= i2c_pkg::M_STOP; // NACK ends the read
                end
                i2c_pkg::M_STOP: begin
                    if (last_cycle) begin
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        state <= i2c_pkg::M_IDLE;
                    end
                end
                default: state <= i2c_pkg::M_IDLE;
            endcase
        end
    end

    done_busy_a: assert property (
        @(posedge clk) disable iff (rst)
        !(done && busy)
    );

    idle_scl_a: assert property (
        @(posedge clk) disable iff (rst)
        state == i2c_pkg::M_IDLE |-> scl_line
    );

endmodule

/* verilog/i2c_phase_gen.sv */
`timescale 1ns/100ps

module i2c_phase_gen #(
    parameter int CLK_FREQ = 40000000,
    parameter int I2C_FREQ = 100000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              run,
    output i2c_pkg::phase_t   phase,
    output logic              last_cycle
);

    localparam int QC = i2c_pkg::quarter_cycles(CLK_FREQ, I2C_FREQ);
    localparam int CW = (QC > 1) ? $clog2(QC) : 1;

    logic [CW-1:0] cnt; // Clocks inside the current quarter

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            cnt   <= '0;
            phase <= i2c_pkg::PH0;
        end else if (cnt == CW'(QC - 1)) begin
            cnt   <= '0;
            phase <= i2c_pkg::phase_t'(phase + 2'd1); // PH3 wraps to PH0
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Final clock of the bit period
    assign last_cycle = run && (phase == i2c_pkg::PH3) && (cnt == CW'(QC - 1));

    // Master only drops run on a bit boundary
    phase_idle_a: assert property (
        @(posedge clk) disable iff (rst)
        !run |-> phase == i2c_pkg::PH0
    );

endmodule

/* verilog/i2c_pkg.sv */
package i2c_pkg;

    typedef logic [7:0] data_t;     // One bus byte
    typedef logic [6:0] dev_addr_t; // Word address on the bus

    // Quarter-bit phases, SCL low in PH0/PH1
    typedef enum logic [1:0] {
        PH0,
        PH1,
        PH2,
        PH3
    } phase_t;

    typedef enum logic [3:0] {
        M_IDLE,
        M_START,
        M_ADDR,
        M_ADDR_ACK,
        M_WRITE,
        M_READ,
        M_SLAVE_ACK,
        M_MASTER_ACK,
        M_STOP
    } master_state_t;

    typedef enum logic [3:0] {
        S_IDLE,
        S_ADDR,
        S_ADDR_ACK,
        S_RX_DATA,
        S_TX_DATA,
        S_RX_ACK,
        S_TX_ACK,
        S_WAIT_STOP
    } slave_state_t;

    typedef struct packed {
        logic      read; // 1 read, 0 write
        dev_addr_t addr;
        data_t     data;
    } i2c_req_t;

    // Open-drain pull-down enables of one agent
    typedef struct packed {
        logic scl_low;
        logic sda_low;
    } bus_drive_t;

    function automatic int quarter_cycles(input int clk_freq, input int i2c_freq);
        return clk_freq / i2c_freq / 4;
    endfunction

endpackage

/* verilog/i2c_slave.sv */
`timescale 1ns/100ps

module i2c_slave #(
    parameter int MEM_DEPTH = 128
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                scl_line,
    input  logic                sda_line,
    output i2c_pkg::bus_drive_t drv
);

    i2c_pkg::slave_state_t state;
    i2c_pkg::data_t        shift;
    i2c_pkg::data_t        mem_rdata;
    i2c_pkg::dev_addr_t    word_addr;
    logic [2:0]            scl_sr;
    logic [2:0]            sda_sr;
    logic [2:0]            bit_cnt;
    logic                  rw;
    logic                  sda_low;
    logic                  mem_rd;
    logic                  mem_wr;
    logic                  sda_in;
    logic                  scl_rise;
    logic                  scl_fall;
    logic                  start_det;
    logic                  stop_det;
    logic                  addr_ok;

    // [1] is the synchronized line, [2] one clock older
    assign sda_in    = sda_sr[1];
    assign scl_rise  = scl_sr[1] & ~scl_sr[2];
    assign scl_fall  = ~scl_sr[1] & scl_sr[2];
    assign start_det = scl_sr[1] & scl_sr[2] & ~sda_sr[1] & sda_sr[2];
    assign stop_det  = scl_sr[1] & scl_sr[2] & sda_sr[1] & ~sda_sr[2];
    assign addr_ok   = int'(shift[7:1]) < MEM_DEPTH;

    // Word stays fetched through the ack bits
    assign mem_rd = (state == i2c_pkg::S_ADDR_ACK && sda_low && rw) ||
                    (state == i2c_pkg::S_RX_ACK);

    assign drv.scl_low = 1'b0;
    assign drv.sda_low = sda_low;

    i2c_word_mem #(
        .MEM_DEPTH(MEM_DEPTH)
    ) mem0 (
        .clk  (clk),
        .rst  (rst),
        .rd_en(mem_rd),
        .wr_en(mem_wr),
        .addr (word_addr),
        .wdata(shift),
        .rdata(mem_rdata)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            scl_sr  <= '1;
            sda_sr  <= '1;
            state   <= i2c_pkg::S_IDLE;
            bit_cnt <= '0;
            rw      <= 1'b0;
            sda_low <= 1'b0;
            mem_wr  <= 1'b0;
        end else begin
            scl_sr <= {scl_sr[1:0], scl_line};
            sda_sr <= {sda_sr[1:0], sda_line};
            mem_wr <= 1'b0;
            if (start_det) begin
                bit_cnt <= '0;
                sda_low <= 1'b0;
                state   <= i2c_pkg::S_ADDR;
            end else if (stop_det) begin
                sda_low <= 1'b0;
                state   <= i2c_pkg::S_IDLE;
            end else begin
                case (state)
                    i2c_pkg::S_ADDR,
                    i2c_pkg::S_RX_DATA: begin
                        if (scl_rise) begin
                            shift   <= {shift[6:0], sda_in};
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7)
                                state <= (state == i2c_pkg::S_ADDR) ? i2c_pkg::S_ADDR_ACK
                                                                    : i2c_pkg::S_TX_ACK;
                        end
                    end
                    i2c_pkg::S_ADDR_ACK: begin
                        // sda_low tells ack start from ack end
                        if (scl_fall && !sda_low) begin
                            if (addr_ok) begin
                                sda_low   <= 1'b1;
                                word_addr <= shift[7:1];
                                rw        <= shift[0];
                            end else begin
                                state <= i2c_pkg::S_WAIT_STOP; // NACK by silence
                            end
                        end else if (scl_fall) begin
                            if (rw) begin
                                shift   <= mem_rdata;
                                sda_low <= ~mem_rdata[7];
                                state   <= i2c_pkg::S_TX_DATA;
                            end else begin
                                sda_low <= 1'b0;
                                state   <= i2c_pkg::S_RX_DATA;
                            end
                        end
                    end
                    i2c_pkg::S_TX_ACK: begin
                        if (scl_fall && !sda_low) begin
                            sda_low <= 1'b1;
                            mem_wr  <= 1'b1;
                        end else if (scl_fall) begin
                            sda_low <= 1'b0;
                            state   <= i2c_pkg::S_WAIT_STOP;
                        end
                    end
                    i2c_pkg::S_TX_DATA: begin
                        if (scl_fall) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                sda_low <= 1'b0; // Free SDA for master ack
                                state   <= i2c_pkg::S_RX_ACK;
                            end else begin
                                shift   <= {shift[6:0], 1'b0};
                                sda_low <= ~shift[6];
                            end
                        end
                    end
                    i2c_pkg::S_RX_ACK: begin
                        if (scl_rise && sda_in) begin
                            state <= i2c_pkg::S_WAIT_STOP;
                        end else if (scl_fall) begin
                            // Master acked, send the word again
                            shift   <= mem_rdata;
                            sda_low <= ~mem_rdata[7];
                            state   <= i2c_pkg::S_TX_DATA;
                        end
                    end
                    i2c_pkg::S_IDLE,
                    i2c_pkg::S_WAIT_STOP: ;
                    default: state <= i2c_pkg::S_IDLE;
                endcase
            end
        end
    end

    mem_wr_range_a: assert property (
        @(posedge clk) disable iff (rst)
        mem_wr |-> int'(word_addr) < MEM_DEPTH
    );

endmodule

/* verilog/i2c_word_mem.sv */
`timescale 1ns/100ps

module i2c_word_mem #(
    parameter int MEM_DEPTH = 128
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               rd_en,
    input  logic               wr_en,
    input  i2c_pkg::dev_addr_t addr,
    input  i2c_pkg::data_t     wdata,
    output i2c_pkg::data_t     rdata
);

    i2c_pkg::data_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_DEPTH; i++)
                mem[i] <= i2c_pkg::data_t'(i); // Word i holds i
        end else if (wr_en) begin
            mem[addr] <= wdata;
        end
    end

    // Registered read, valid one clock after rd_en
    always_ff @(posedge clk) begin
        if (rd_en)
            rdata <= mem[addr];
    end

endmodule
